/* lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ************************************************************
// memory map
// ************************************************************

`define MEM_BASE    32'h8000_0000 // first byte of the on-chip memory.
`define MEM_BYTES   32'd4096
`define RESET_PC    `MEM_BASE     // fetch starts at the bottom of memory.

// ************************************************************
// bus response codes
// ************************************************************

`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10 // address outside the memory.

`endif

/* lsu_pkg.sv */
package lsu_pkg;

    // ************************************************************
    // execute-stage request and writeback response
    // ************************************************************

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_kind_e;

    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } mem_width_e;

    typedef struct packed {
        mem_kind_e   kind;
        mem_width_e  width;
        logic        sext;  // sign-extend narrow loads.
        logic [4:0]  rd;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        is_load;
        logic        fault;
        logic [31:0] data;
    } lsu_resp_t;

    // ************************************************************
    // AXI4-Lite, split by driving side
    // ************************************************************

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axi_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axi_rsp_t;

endpackage

/* load_store_unit.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module load_store_unit import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  lsu_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output lsu_resp_t resp,
    output axi_req_t  bus_req,
    input  axi_rsp_t  bus_rsp
);
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_busy = 2'd1,
        st_done = 2'd2
    } state_e;

    state_e      state_q;
    logic        live_q;
    lsu_req_t    req_q;
    lsu_resp_t   resp_q;
    logic        awvalid_q;
    logic        wvalid_q;
    logic        bready_q;
    logic        arvalid_q;
    logic        rready_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic [4:0]  st_shift;
    logic [4:0]  ld_shift;
    logic [31:0] wdata_al;
    logic [3:0]  wstrb_al;
    logic [31:0] rlane;
    logic [31:0] rdata_fmt;
    logic        accept;
    logic        r_done;
    logic        b_done;

    assign req_ready  = live_q && (state_q == st_idle);
    assign accept     = req_valid && req_ready;
    assign r_done     = rready_q && bus_rsp.rvalid;
    assign b_done     = bready_q && bus_rsp.bvalid;
    assign resp_valid = (state_q == st_done);
    assign resp       = resp_q;

    // ************************************************************
    // store lane alignment and load formatting
    // ************************************************************

    assign st_shift = {req.addr[1:0], 3'b000};
    assign wdata_al = req.wdata << st_shift;

    always_comb begin
        case (req.width)
            width_byte: wstrb_al = 4'b0001 << req.addr[1:0];
            width_half: wstrb_al = 4'b0011 << req.addr[1:0];
            default:    wstrb_al = 4'b1111;
        endcase
    end

    assign ld_shift = {req_q.addr[1:0], 3'b000};
    assign rlane    = bus_rsp.rdata >> ld_shift; // addressed lane down to bit 0.

    always_comb begin
        case (req_q.width)
            width_byte: rdata_fmt = req_q.sext ? {{24{rlane[7]}}, rlane[7:0]}
                                               : {24'b0, rlane[7:0]};
            width_half: rdata_fmt = req_q.sext ? {{16{rlane[15]}}, rlane[15:0]}
                                               : {16'b0, rlane[15:0]};
            default:    rdata_fmt = rlane;
        endcase
    end

    // ************************************************************
    // control
    // ************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= st_idle;
            live_q    <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            bready_q  <= 1'b0;
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
        end else begin
            live_q <= 1'b1;
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        case (req.kind)
                            mem_load: begin
                                arvalid_q <= 1'b1;
                                rready_q  <= 1'b1;
                                state_q   <= st_busy;
                            end
                            mem_store: begin
                                awvalid_q <= 1'b1;
                                wvalid_q  <= 1'b1;
                                bready_q  <= 1'b1;
                                state_q   <= st_busy;
                            end
                            default: state_q <= st_done; // pass-through needs no bus traffic.
                        endcase
                    end
                end
                st_busy: begin
                    if (arvalid_q && bus_rsp.arready) arvalid_q <= 1'b0;
                    if (awvalid_q && bus_rsp.awready) awvalid_q <= 1'b0;
                    if (wvalid_q && bus_rsp.wready) wvalid_q <= 1'b0;
                    if (r_done) rready_q <= 1'b0;
                    if (b_done) bready_q <= 1'b0;
                    if (r_done || b_done) state_q <= st_done;
                end
                st_done: begin
                    if (resp_ready) state_q <= st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q   <= req;
            wdata_q <= wdata_al;
            wstrb_q <= wstrb_al;
            resp_q  <= '{rd: req.rd, is_load: 1'b0, fault: 1'b0, data: req.addr};
        end
        if (r_done) begin
            resp_q <= '{rd: req_q.rd, is_load: 1'b1,
                        fault: (bus_rsp.rresp != `RESP_OKAY), data: rdata_fmt};
        end
        if (b_done) begin
            resp_q <= '{rd: req_q.rd, is_load: 1'b0,
                        fault: (bus_rsp.bresp != `RESP_OKAY), data: 32'b0};
        end
    end

    always_comb begin
        bus_req.awvalid = awvalid_q;
        bus_req.awaddr  = req_q.addr;
        bus_req.wvalid  = wvalid_q;
        bus_req.wdata   = wdata_q;
        bus_req.wstrb   = wstrb_q;
        bus_req.bready  = bready_q;
        bus_req.arvalid = arvalid_q;
        bus_req.araddr  = req_q.addr;
        bus_req.rready  = rready_q;
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module fetch_unit import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output axi_req_t    bus_req,
    input  axi_rsp_t    bus_rsp
);
    logic [31:0] pc_q;
    logic [31:0] araddr_q;
    logic [31:0] inst_q;
    logic        arvalid_q;
    logic        rready_q;
    logic        drop_q;
    logic        inst_valid_q;
    logic        in_flight;
    logic        go;
    logic        r_hs;

    assign in_flight = arvalid_q || rready_q;
    assign go        = !in_flight && !inst_valid_q; // one read at a time.
    assign r_hs      = rready_q && bus_rsp.rvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q         <= `RESET_PC;
            arvalid_q    <= 1'b0;
            rready_q     <= 1'b0;
            drop_q       <= 1'b0;
            inst_valid_q <= 1'b0;
        end else begin
            if (go) arvalid_q <= 1'b1;
            if (arvalid_q && bus_rsp.arready) begin
                arvalid_q <= 1'b0;
                rready_q  <= 1'b1;
            end
            if (r_hs) rready_q <= 1'b0;

            // a redirect lets the open read finish but discards its word.
            if (r_hs) drop_q <= 1'b0;
            else if (redirect_valid && in_flight) drop_q <= 1'b1;

            if (redirect_valid) inst_valid_q <= 1'b0;
            else if (r_hs && !drop_q) inst_valid_q <= 1'b1;
            else if (inst_valid_q && inst_ready) inst_valid_q <= 1'b0;

            if (redirect_valid) pc_q <= redirect_pc;
            else if (inst_valid_q && inst_ready) pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (go) araddr_q <= redirect_valid ? redirect_pc : pc_q;
        if (r_hs) inst_q <= bus_rsp.rdata;
    end

    assign inst_valid = inst_valid_q;
    assign inst       = inst_q;
    assign inst_pc    = araddr_q; // address of the held word.

    always_comb begin
        bus_req         = '0; // read-only master.
        bus_req.arvalid = arvalid_q;
        bus_req.araddr  = araddr_q;
        bus_req.rready  = rready_q;
    end

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t m0_req,
    output axi_rsp_t m0_rsp,
    input  axi_req_t m1_req,
    output axi_rsp_t m1_rsp,
    output axi_req_t s_req,
    input  axi_rsp_t s_rsp
);
    logic busy_q;
    logic grant_q;
    logic last_q;
    logic want0;
    logic want1;
    logic sel;
    logic active;
    logic done;

    // ************************************************************
    // grant selection
    // ************************************************************

    assign want0 = m0_req.arvalid || m0_req.awvalid;
    assign want1 = m1_req.arvalid || m1_req.awvalid;

    always_comb begin
        if (busy_q) begin
            sel = grant_q;
        end else if (want0 && want1) begin
            sel = ~last_q; // round-robin between the peers.
        end else begin
            sel = want1;
        end
    end

    assign active = busy_q || want0 || want1;

    // ************************************************************
    // routing
    // ************************************************************

    always_comb begin
        s_req  = '0;
        m0_rsp = '0;
        m1_rsp = '0;
        if (active) begin
            if (sel) begin
                s_req  = m1_req;
                m1_rsp = s_rsp;
            end else begin
                s_req  = m0_req;
                m0_rsp = s_rsp;
            end
        end
    end

    // transaction ends on the response handshake of the granted master.
    assign done = (s_req.rready && s_rsp.rvalid) || (s_req.bready && s_rsp.bvalid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q  <= 1'b0;
            grant_q <= 1'b0;
            last_q  <= 1'b1; // fetch wins the first tie.
        end else begin
            if (!busy_q) begin
                if (want0 || want1) begin
                    busy_q  <= 1'b1;
                    grant_q <= sel;
                end
            end else if (done) begin
                busy_q <= 1'b0;
                last_q <= grant_q;
            end
        end
    end

endmodule

/* axi_sram.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module axi_sram import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t bus_req,
    output axi_rsp_t bus_rsp
);
    localparam int DEPTH = `MEM_BYTES / 4;
    localparam int IW    = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [31:0]   ar_off;
    logic [31:0]   aw_off;
    logic [IW-1:0] ar_idx;
    logic [IW-1:0] aw_idx;
    logic          ar_in;
    logic          aw_in;
    logic          ar_hs;
    logic          w_go;
    logic          rvalid_q;
    logic          bvalid_q;
    logic [31:0]   rdata_q;
    logic [1:0]    rresp_q;
    logic [1:0]    bresp_q;

    // unsigned offset covers both range bounds in one compare.
    assign ar_off = bus_req.araddr - `MEM_BASE;
    assign aw_off = bus_req.awaddr - `MEM_BASE;
    assign ar_in  = ar_off < `MEM_BYTES;
    assign aw_in  = aw_off < `MEM_BYTES;
    assign ar_idx = ar_off[IW+1:2];
    assign aw_idx = aw_off[IW+1:2];

    assign ar_hs = bus_req.arvalid && !rvalid_q;
    assign w_go  = bus_req.awvalid && bus_req.wvalid && !bvalid_q; // address and data together.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (ar_hs) rvalid_q <= 1'b1;
            else if (rvalid_q && bus_req.rready) rvalid_q <= 1'b0;
            if (w_go) bvalid_q <= 1'b1;
            else if (bvalid_q && bus_req.bready) bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= ar_in ? mem[ar_idx] : 32'b0;
            rresp_q <= ar_in ? `RESP_OKAY : `RESP_SLVERR;
        end
        if (w_go) begin
            bresp_q <= aw_in ? `RESP_OKAY : `RESP_SLVERR;
            for (int b = 0; b < 4; b++) begin
                if (aw_in && bus_req.wstrb[b]) mem[aw_idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        bus_rsp.awready = w_go;
        bus_rsp.wready  = w_go;
        bus_rsp.bvalid  = bvalid_q;
        bus_rsp.bresp   = bresp_q;
        bus_rsp.arready = !rvalid_q;
        bus_rsp.rvalid  = rvalid_q;
        bus_rsp.rdata   = rdata_q;
        bus_rsp.rresp   = rresp_q;
    end

endmodule

/* mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    output logic        req_ready,
    input  lsu_req_t    req,
    output logic        resp_valid,
    input  logic        resp_ready,
    output lsu_resp_t   resp,
    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc
);
    axi_req_t f_req;
    axi_rsp_t f_rsp;
    axi_req_t l_req;
    axi_rsp_t l_rsp;
    axi_req_t s_req;
    axi_rsp_t s_rsp;

    fetch_unit u_fetch (.clk, .rst, .inst_valid, .inst_ready, .inst, .inst_pc,
        .redirect_valid, .redirect_pc, .bus_req(f_req), .bus_rsp(f_rsp));

    load_store_unit u_lsu (.clk, .rst, .req_valid, .req_ready, .req,
        .resp_valid, .resp_ready, .resp, .bus_req(l_req), .bus_rsp(l_rsp));

    // port 0 is fetch and port 1 is load/store.
    bus_arbiter u_arb (.clk, .rst, .m0_req(f_req), .m0_rsp(f_rsp),
        .m1_req(l_req), .m1_rsp(l_rsp), .s_req(s_req), .s_rsp(s_rsp));

    axi_sram u_sram (.clk, .rst, .bus_req(s_req), .bus_rsp(s_rsp));

endmodule

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_mem_subsystem import lsu_pkg::*; ();
    localparam int CLK_PERIOD = 40;
    localparam int NUM_OPS    = 63; // bus operations and fetched words over all tests.
    localparam int OP_CYCLES  = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    lsu_req_t    req;
    logic        resp_valid;
    logic        resp_ready;
    lsu_resp_t   resp;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    string       test_name;
    logic [31:0] rt_addr [8]; // round-trip words that the fetch test loads again.
    logic [31:0] rt_data [8];

    mem_subsystem_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (NUM_OPS * OP_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", NUM_OPS * OP_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ************************************************************
    // helpers
    // ************************************************************

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // called on a falling edge and returns on one.
    task automatic lsu_op(input mem_kind_e kind, input mem_width_e width, input logic sext,
                          input logic [4:0] rd, input logic [31:0] addr,
                          input logic [31:0] wdata, output lsu_resp_t result);
        req.kind  = kind;
        req.width = width;
        req.sext  = sext;
        req.rd    = rd;
        req.addr  = addr;
        req.wdata = wdata;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        while (!resp_valid) @(negedge clk);
        result = resp;
        @(negedge clk); // taken on the edge in between.
    endtask

    task automatic store_data(input mem_width_e width, input logic [31:0] addr,
                              input logic [31:0] data, output lsu_resp_t result);
        lsu_op(mem_store, width, 1'b0, 5'd0, addr, data, result);
    endtask

    task automatic load_data(input mem_width_e width, input logic sext,
                             input logic [31:0] addr, output lsu_resp_t result);
        lsu_op(mem_load, width, sext, 5'd1, addr, 32'h0, result);
    endtask

    function automatic logic [31:0] extract_lane(input logic [31:0] word, input int off,
                                                 input mem_width_e width, input logic sext);
        logic [7:0]  lane8;
        logic [15:0] lane16;
        lane8  = 8'(word >> (8 * off));
        lane16 = 16'(word >> (8 * off));
        if (width == width_byte) return sext ? 32'($signed(lane8)) : 32'(lane8);
        if (width == width_half) return sext ? 32'($signed(lane16)) : 32'(lane16);
        return word;
    endfunction

    task automatic report_test(input int errors_before);
        tests_run++;
        if (errors == errors_before) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, errors - errors_before);
    endtask

    // ************************************************************
    // tests
    // ************************************************************

    task automatic word_round_trip();
        lsu_resp_t r;
        int        e0;
        test_name = "word_round_trip";
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            rt_addr[i] = `MEM_BASE + 32'(i * 256) + 32'(($random(seed) & 63) * 4);
            rt_data[i] = $random(seed);
            store_data(width_word, rt_addr[i], rt_data[i], r);
            compare_value("store fault", 32'(0), 32'(r.fault));
        end
        for (int i = 0; i < 8; i++) begin
            load_data(width_word, 1'b0, rt_addr[i], r);
            compare_value("load data", rt_data[i], r.data);
            compare_value("load fault", 32'(0), 32'(r.fault));
            compare_value("is_load", 32'(1), 32'(r.is_load));
        end
        report_test(e0);
    endtask

    task automatic byte_half_strobes();
        lsu_resp_t   r;
        int          e0;
        logic [31:0] addr;
        logic [31:0] base_word;
        logic [31:0] noise;
        logic [7:0]  b;
        logic [15:0] h;
        test_name = "byte_half_strobes";
        e0 = errors;
        addr      = `MEM_BASE + 32'h900;
        base_word = $random(seed);
        noise     = $random(seed); // upper bits must be masked by the strobes.
        b         = 8'($random(seed));
        h         = 16'($random(seed));
        store_data(width_word, addr, base_word, r);
        store_data(width_byte, addr + 32'd1, {noise[31:8], b}, r);
        store_data(width_half, addr + 32'd2, {noise[31:16], h}, r);
        load_data(width_word, 1'b0, addr, r);
        compare_value("merged word", {h, b, base_word[7:0]}, r.data);
        report_test(e0);
    endtask

    task automatic load_extension();
        lsu_resp_t   r;
        int          e0;
        logic [31:0] addr;
        logic [31:0] known;
        test_name = "load_extension";
        e0 = errors;
        addr  = `MEM_BASE + 32'hA00;
        known = 32'h80F1_7F82; // lanes with both sign bit values.
        store_data(width_word, addr, known, r);
        for (int off = 0; off < 4; off++) begin
            for (int s = 0; s < 2; s++) begin
                load_data(width_byte, 1'(s), addr + 32'(off), r);
                compare_value("byte lane", extract_lane(known, off, width_byte, 1'(s)), r.data);
            end
        end
        for (int off = 0; off < 4; off += 2) begin
            for (int s = 0; s < 2; s++) begin
                load_data(width_half, 1'(s), addr + 32'(off), r);
                compare_value("half lane", extract_lane(known, off, width_half, 1'(s)), r.data);
            end
        end
        report_test(e0);
    endtask

    task automatic access_fault();
        lsu_resp_t   r;
        int          e0;
        logic [31:0] good_addr;
        logic [31:0] good;
        test_name = "access_fault";
        e0 = errors;
        good_addr = `MEM_BASE + 32'hB00;
        good      = $random(seed);
        store_data(width_word, good_addr, good, r);
        compare_value("good store fault", 32'(0), 32'(r.fault));
        store_data(width_word, good_addr + `MEM_BYTES, ~good, r); // aliases good_addr if wrapped.
        compare_value("bad store fault", 32'(1), 32'(r.fault));
        compare_value("bad store is_load", 32'(0), 32'(r.is_load));
        load_data(width_word, 1'b0, `MEM_BASE - 32'd4, r);
        compare_value("bad load fault", 32'(1), 32'(r.fault));
        compare_value("bad load data", 32'h0, r.data);
        load_data(width_word, 1'b0, good_addr, r);
        compare_value("reload data", good, r.data);
        compare_value("reload fault", 32'(0), 32'(r.fault));
        report_test(e0);
    endtask

    task automatic pass_through();
        lsu_resp_t   r;
        int          e0;
        logic [31:0] addr;
        logic [4:0]  rd;
        test_name = "pass_through";
        e0 = errors;
        for (int k = 0; k < 2; k++) begin
            addr = $random(seed);
            rd   = 5'($random(seed));
            lsu_op(mem_none, width_word, 1'b0, rd, addr, 32'h0, r);
            compare_value("data", addr, r.data);
            compare_value("rd", 32'(rd), 32'(r.rd));
            compare_value("is_load", 32'(0), 32'(r.is_load));
            compare_value("fault", 32'(0), 32'(r.fault));
        end
        report_test(e0);
    endtask

    task automatic fetch_stream();
        lsu_resp_t   r;
        int          e0;
        logic [31:0] start;
        logic [31:0] seq [8];
        logic [31:0] got_inst [8];
        logic [31:0] got_pc [8];
        test_name = "fetch_stream";
        e0 = errors;
        start = `MEM_BASE + 32'hC00;
        for (int i = 0; i < 8; i++) begin
            seq[i] = $random(seed);
            store_data(width_word, start + 32'(i * 4), seq[i], r);
        end
        redirect_pc    = start;
        redirect_valid = 1'b1;
        @(negedge clk);
        redirect_valid = 1'b0;
        fork
            begin
                for (int n = 0; n < 8; n++) begin
                    while (!inst_valid) @(negedge clk);
                    got_inst[n] = inst;
                    got_pc[n]   = inst_pc;
                    @(negedge clk); // the word is consumed since inst_ready is high.
                end
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    load_data(width_word, 1'b0, rt_addr[i], r);
                    compare_value("load during fetch", rt_data[i], r.data);
                end
            end
        join
        for (int n = 0; n < 8; n++) begin
            compare_value("inst", seq[n], got_inst[n]);
            compare_value("inst_pc", start + 32'(n * 4), got_pc[n]);
        end
        report_test(e0);
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************

    initial begin
        seed           = 32'h633d;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        rst            = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        resp_ready     = 1'b1;
        inst_ready     = 1'b1; // fetch runs freely through every test.
        redirect_valid = 1'b0;
        redirect_pc    = 32'h0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        word_round_trip();
        byte_half_strobes();
        load_extension();
        access_fault();
        pass_through();
        fetch_stream();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
lsu_pkg.sv
load_store_unit.sv
fetch_unit.sv
bus_arbiter.sv
axi_sram.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the memory subsystem testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_mem_subsystem -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "run_sim: verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "run_sim: testbench reported failure"
    exit 1
fi

echo "run_sim: no failure reported"
exit 0
